// ==== hw/wbaxi_defines.svh ====
`ifndef WBAXI_DEFINES_SVH
`define WBAXI_DEFINES_SVH

// byte address width on both the wishbone port and the axi side
`define WBAXI_ADDR_WIDTH 16

// data width, strobes are derived from it
`define WBAXI_DATA_WIDTH 32

// cycles the host waits for a response before giving up
`define WBAXI_RESP_TIMEOUT 8'h40

// registers in the bank, must stay a power of two for the aliasing
`define WBAXI_REG_COUNT 16

// identification word returned by register 0
`define WBAXI_ID 32'h5742_4158

`endif

// ==== hw/wbaxi_pkg.sv ====
package wbaxi_pkg;

  // axi4-lite bresp / rresp encoding
  typedef enum logic [1:0] {
    okay   = 2'b00, // normal access
    exokay = 2'b01, // exclusive ok, never produced here
    slverr = 2'b10, // slave refused the access
    decerr = 2'b11  // nothing decoded at that address
  } axi_resp_e;

  // wishbone bridge sequencing
  typedef enum logic [1:0] {
    idle       = 2'b00, // no cycle in flight
    wait_write = 2'b01, // write strobe issued, waiting for busy to drop
    wait_read  = 2'b10, // read strobe issued, waiting for rvalid
    done       = 2'b11  // ack or err on the bus this cycle
  } bridge_state_e;

endpackage

// ==== hw/axi_host_pipelined.sv ====
`include "wbaxi_defines.svh"

// axi4-lite master driven by single-cycle read/write strobes
// a read and a write may overlap, each channel only needs its own busy flag low
module axi_host_pipelined (
   input  logic                                m_axi_aclk
  ,input  logic                                m_axi_aresetn
  // write address channel
  ,output logic [`WBAXI_ADDR_WIDTH-1:0]        m_axi_awaddr
  ,output logic [2:0]                          m_axi_awprot
  ,output logic                                m_axi_awvalid
  ,input  logic                                m_axi_awready
  // write data channel
  ,output logic [`WBAXI_DATA_WIDTH-1:0]        m_axi_wdata
  ,output logic [`WBAXI_DATA_WIDTH/8-1:0]      m_axi_wstrb
  ,output logic                                m_axi_wvalid
  ,input  logic                                m_axi_wready
  // write response channel
  ,input  logic [1:0]                          m_axi_bresp
  ,input  logic                                m_axi_bvalid
  ,output logic                                m_axi_bready
  // read address channel
  ,output logic [`WBAXI_ADDR_WIDTH-1:0]        m_axi_araddr
  ,output logic [2:0]                          m_axi_arprot
  ,output logic                                m_axi_arvalid
  ,input  logic                                m_axi_arready
  // read data channel
  ,input  logic [`WBAXI_DATA_WIDTH-1:0]        m_axi_rdata
  ,input  logic [1:0]                          m_axi_rresp
  ,input  logic                                m_axi_rvalid
  ,output logic                                m_axi_rready
  // strobe side
  ,input  logic                                read_stb   // starts a read
  ,input  logic                                write_stb  // starts a write
  ,input  logic [`WBAXI_ADDR_WIDTH-1:0]        addr
  ,input  logic [`WBAXI_DATA_WIDTH-1:0]        wdata
  ,output logic [`WBAXI_DATA_WIDTH-1:0]        rdata
  ,output logic                                busy_r     // read address still pending
  ,output logic                                busy_w     // write address or data pending
  ,output logic                                busy       // some response outstanding
  ,output logic                                rvalid     // one cycle, rdata and resp valid
  ,output logic                                timeout    // one cycle, transaction abandoned
  ,output wbaxi_pkg::axi_resp_e                resp       // last bresp or rresp
);

  localparam int strb_w = `WBAXI_DATA_WIDTH / 8;

  logic       awaiting_bresp; // write issued, no bresp yet
  logic       awaiting_rdata; // read issued, no rdata yet
  logic [7:0] resp_count;     // cycles since the last strobe

  logic bresp_fire;
  logic rresp_fire;
  logic read_start;

  // always a plain secure data access
  assign m_axi_awprot = 3'b000;
  assign m_axi_arprot = 3'b000;

  assign busy_r = m_axi_arvalid;
  assign busy_w = m_axi_awvalid | m_axi_wvalid;
  assign busy   = awaiting_bresp | awaiting_rdata;

  assign bresp_fire = awaiting_bresp && m_axi_bready && m_axi_bvalid;
  assign rresp_fire = m_axi_rready && m_axi_rvalid;
  assign read_start = !m_axi_arvalid && read_stb; // a pending araddr blocks a new read

  always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
    if (!m_axi_aresetn) begin
      m_axi_awvalid  <= 1'b0;
      m_axi_wvalid   <= 1'b0;
      m_axi_arvalid  <= 1'b0;
      m_axi_bready   <= 1'b0;
      m_axi_rready   <= 1'b0;
      rvalid         <= 1'b0;
      timeout        <= 1'b0;
      awaiting_bresp <= 1'b0;
      awaiting_rdata <= 1'b0;
      resp_count     <= 8'h00;
    end else begin
      // single-cycle strobes
      timeout <= 1'b0;
      rvalid  <= 1'b0;

      // retire address and data handshakes
      if (m_axi_awvalid && m_axi_awready) m_axi_awvalid <= 1'b0;
      if (m_axi_wvalid && m_axi_wready) m_axi_wvalid <= 1'b0;
      if (m_axi_arvalid && m_axi_arready) m_axi_arvalid <= 1'b0;

      // response watchdog, shared by both directions
      if (busy) begin
        if (resp_count == `WBAXI_RESP_TIMEOUT) begin
          timeout        <= 1'b1;
          awaiting_bresp <= 1'b0;
          awaiting_rdata <= 1'b0;
          m_axi_awvalid  <= 1'b0; // drop whatever the slave never took
          m_axi_wvalid   <= 1'b0;
          m_axi_arvalid  <= 1'b0;
          m_axi_bready   <= 1'b0;
          m_axi_rready   <= 1'b0;
        end else begin
          resp_count <= resp_count + 8'd1;
        end
      end

      if (bresp_fire) awaiting_bresp <= 1'b0;

      // new write, overrides the clears above
      if (write_stb) begin
        resp_count     <= 8'h00;
        m_axi_awvalid  <= 1'b1;
        m_axi_wvalid   <= 1'b1;
        m_axi_bready   <= 1'b1; // stays up until a timeout
        awaiting_bresp <= 1'b1;
      end

      if (rresp_fire) begin
        rvalid         <= 1'b1;
        awaiting_rdata <= 1'b0;
      end

      // new read
      if (read_start) begin
        resp_count     <= 8'h00;
        m_axi_arvalid  <= 1'b1;
        m_axi_rready   <= 1'b1;
        awaiting_rdata <= 1'b1;
      end
    end
  end

  // address, data and response words
  always_ff @(posedge m_axi_aclk) begin
    if (m_axi_wvalid && m_axi_wready) m_axi_wstrb <= '0;
    if (write_stb) begin
      m_axi_awaddr <= addr;
      m_axi_wdata  <= wdata;
      m_axi_wstrb  <= {strb_w{1'b1}}; // full word writes only
    end
    if (bresp_fire) resp <= wbaxi_pkg::axi_resp_e'(m_axi_bresp);
    if (rresp_fire) begin
      rdata <= m_axi_rdata;
      resp  <= wbaxi_pkg::axi_resp_e'(m_axi_rresp); // read wins if both land together
    end
    if (read_start) m_axi_araddr <= addr;
  end

endmodule

// ==== hw/wb_host_bridge.sv ====
`include "wbaxi_defines.svh"

// wishbone classic slave in front of the strobe interface of the axi host
// one transaction at a time, so busy_r / busy_w are not needed
module wb_host_bridge (
   input  logic                           m_axi_aclk
  ,input  logic                           m_axi_aresetn
  // wishbone side
  ,input  logic                           cyc
  ,input  logic                           stb
  ,input  logic                           we
  ,input  logic [`WBAXI_ADDR_WIDTH-1:0]   adr
  ,input  logic [`WBAXI_DATA_WIDTH-1:0]   dat_w
  ,output logic [`WBAXI_DATA_WIDTH-1:0]   dat_r  // valid with ack of a read
  ,output logic                           ack
  ,output logic                           err
  // host side
  ,output logic                           read_stb
  ,output logic                           write_stb
  ,output logic [`WBAXI_ADDR_WIDTH-1:0]   addr
  ,output logic [`WBAXI_DATA_WIDTH-1:0]   wdata
  ,input  logic                           busy
  ,input  logic                           rvalid
  ,input  logic [`WBAXI_DATA_WIDTH-1:0]   rdata
  ,input  logic                           timeout
  ,input  wbaxi_pkg::axi_resp_e           resp
);

  wbaxi_pkg::bridge_state_e state;

  logic launch;   // new wishbone cycle accepted this edge
  logic resp_ok;  // only okay maps to ack, exokay included as an error
  logic wr_done;  // write finished normally
  logic rd_done;  // read finished normally

  assign launch  = (state == wbaxi_pkg::idle) && cyc && stb;
  assign resp_ok = (resp == wbaxi_pkg::okay);
  // busy only rises the cycle after the strobe, so skip the strobe cycle
  assign wr_done = (state == wbaxi_pkg::wait_write) && !write_stb && !busy;
  assign rd_done = (state == wbaxi_pkg::wait_read) && rvalid;

  always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
    if (!m_axi_aresetn) begin
      state     <= wbaxi_pkg::idle;
      read_stb  <= 1'b0;
      write_stb <= 1'b0;
      ack       <= 1'b0;
      err       <= 1'b0;
    end else begin
      read_stb  <= 1'b0;
      write_stb <= 1'b0;
      ack       <= 1'b0; // ack and err are one-cycle pulses
      err       <= 1'b0;
      case (state)
        wbaxi_pkg::idle: begin
          if (launch) begin
            write_stb <= we;
            read_stb  <= !we;
            state     <= we ? wbaxi_pkg::wait_write : wbaxi_pkg::wait_read;
          end
        end
        wbaxi_pkg::wait_write,
        wbaxi_pkg::wait_read: begin
          // timeout first, busy is already low in that cycle
          if (timeout) begin
            err   <= 1'b1;
            state <= wbaxi_pkg::done;
          end else if (wr_done || rd_done) begin
            ack   <= resp_ok;
            err   <= !resp_ok;
            state <= wbaxi_pkg::done;
          end
        end
        wbaxi_pkg::done: state <= wbaxi_pkg::idle; // master sees ack here, cycle over
        default: state <= wbaxi_pkg::idle;
      endcase
    end
  end

  // request and read data words
  always_ff @(posedge m_axi_aclk) begin
    if (launch) begin
      addr  <= adr;
      wdata <= dat_w;
    end
    if (rd_done) dat_r <= rdata;
  end

endmodule

// ==== hw/axil_reg_slave.sv ====
`include "wbaxi_defines.svh"

// axi4-lite register bank
// lower half of the address space maps the bank, aliased by word index
// upper half never raises a ready, which looks like a hung peripheral
module axil_reg_slave (
   input  logic                              m_axi_aclk
  ,input  logic                              m_axi_aresetn
  ,input  logic [`WBAXI_ADDR_WIDTH-1:0]      awaddr
  ,input  logic [2:0]                        awprot
  ,input  logic                              awvalid
  ,output logic                              awready
  ,input  logic [`WBAXI_DATA_WIDTH-1:0]      wdata
  ,input  logic [`WBAXI_DATA_WIDTH/8-1:0]    wstrb
  ,input  logic                              wvalid
  ,output logic                              wready
  ,output wbaxi_pkg::axi_resp_e              bresp
  ,output logic                              bvalid
  ,input  logic                              bready
  ,input  logic [`WBAXI_ADDR_WIDTH-1:0]      araddr
  ,input  logic [2:0]                        arprot
  ,input  logic                              arvalid
  ,output logic                              arready
  ,output logic [`WBAXI_DATA_WIDTH-1:0]      rdata
  ,output wbaxi_pkg::axi_resp_e              rresp
  ,output logic                              rvalid
  ,input  logic                              rready
);

  localparam int idx_w  = $clog2(`WBAXI_REG_COUNT);
  localparam int strb_w = `WBAXI_DATA_WIDTH / 8;

  // register 0 is the id word and has no storage
  logic [`WBAXI_DATA_WIDTH-1:0] regs [1:`WBAXI_REG_COUNT-1];

  logic [idx_w-1:0] wr_idx;
  logic [idx_w-1:0] rd_idx;
  logic             wr_mapped;
  logic             rd_mapped;
  logic             wr_fire;
  logic             rd_fire;
  logic             wr_err;
  logic             rd_err;

  assign wr_idx    = awaddr[idx_w+1:2]; // upper index bits dropped, gives the aliasing
  assign rd_idx    = araddr[idx_w+1:2];
  assign wr_mapped = !awaddr[`WBAXI_ADDR_WIDTH-1];
  assign rd_mapped = !araddr[`WBAXI_ADDR_WIDTH-1];
  assign wr_fire   = awvalid && awready && wvalid && wready;
  assign rd_fire   = arvalid && arready;

  // id word is read-only, and the bank only takes secure accesses (prot[1] low)
  assign wr_err = (wr_idx == '0) || awprot[1];
  assign rd_err = arprot[1];

  always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
    if (!m_axi_aresetn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      for (int i = 1; i < `WBAXI_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // readies are single-cycle pulses
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;

      // take address and data together, one write in flight
      if (awvalid && wvalid && wr_mapped && !awready && !bvalid) begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
      if (bvalid && bready) bvalid <= 1'b0;
      if (wr_fire) begin
        bvalid <= 1'b1; // response the cycle after the handshake
        if (!wr_err) begin
          for (int b = 0; b < strb_w; b++) begin
            if (wstrb[b]) regs[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
      end

      // read side, same one-deep scheme
      if (arvalid && rd_mapped && !arready && !rvalid) arready <= 1'b1;
      if (rvalid && rready) rvalid <= 1'b0;
      if (rd_fire) rvalid <= 1'b1;
    end
  end

  // response words, only looked at with their valid
  always_ff @(posedge m_axi_aclk) begin
    if (wr_fire) bresp <= wr_err ? wbaxi_pkg::slverr : wbaxi_pkg::okay;
    if (rd_fire) begin
      rdata <= (rd_idx == '0) ? `WBAXI_ID : regs[rd_idx];
      rresp <= rd_err ? wbaxi_pkg::slverr : wbaxi_pkg::okay;
    end
  end

endmodule

// ==== hw/wbaxi_top.sv ====
`include "wbaxi_defines.svh"

// wishbone slave port -> strobe bridge -> axi4-lite host -> register bank
module wbaxi_top (
   input  logic                           m_axi_aclk
  ,input  logic                           m_axi_aresetn
  ,input  logic                           cyc
  ,input  logic                           stb
  ,input  logic                           we
  ,input  logic [`WBAXI_ADDR_WIDTH-1:0]   adr
  ,input  logic [`WBAXI_DATA_WIDTH-1:0]   dat_w
  ,output logic [`WBAXI_DATA_WIDTH-1:0]   dat_r
  ,output logic                           ack
  ,output logic                           err
);

  // bridge <-> host strobe interface
  logic                           read_stb;
  logic                           write_stb;
  logic [`WBAXI_ADDR_WIDTH-1:0]   host_addr;
  logic [`WBAXI_DATA_WIDTH-1:0]   host_wdata;
  logic [`WBAXI_DATA_WIDTH-1:0]   host_rdata;
  logic                           host_busy;
  logic                           host_rvalid;
  logic                           host_timeout;
  wbaxi_pkg::axi_resp_e           host_resp;

  // host <-> bank axi4-lite
  logic [`WBAXI_ADDR_WIDTH-1:0]   axi_awaddr;
  logic [2:0]                     axi_awprot;
  logic                           axi_awvalid;
  logic                           axi_awready;
  logic [`WBAXI_DATA_WIDTH-1:0]   axi_wdata;
  logic [`WBAXI_DATA_WIDTH/8-1:0] axi_wstrb;
  logic                           axi_wvalid;
  logic                           axi_wready;
  logic [1:0]                     axi_bresp;
  logic                           axi_bvalid;
  logic                           axi_bready;
  logic [`WBAXI_ADDR_WIDTH-1:0]   axi_araddr;
  logic [2:0]                     axi_arprot;
  logic                           axi_arvalid;
  logic                           axi_arready;
  logic [`WBAXI_DATA_WIDTH-1:0]   axi_rdata;
  logic [1:0]                     axi_rresp;
  logic                           axi_rvalid;
  logic                           axi_rready;

  wb_host_bridge u_bridge (
     .m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn)
    ,.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w)
    ,.dat_r(dat_r), .ack(ack), .err(err)
    ,.read_stb(read_stb), .write_stb(write_stb), .addr(host_addr), .wdata(host_wdata)
    ,.busy(host_busy), .rvalid(host_rvalid), .rdata(host_rdata)
    ,.timeout(host_timeout), .resp(host_resp)
  );

  axi_host_pipelined u_host (
     .m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn)
    ,.m_axi_awaddr(axi_awaddr), .m_axi_awprot(axi_awprot)
    ,.m_axi_awvalid(axi_awvalid), .m_axi_awready(axi_awready)
    ,.m_axi_wdata(axi_wdata), .m_axi_wstrb(axi_wstrb)
    ,.m_axi_wvalid(axi_wvalid), .m_axi_wready(axi_wready)
    ,.m_axi_bresp(axi_bresp), .m_axi_bvalid(axi_bvalid), .m_axi_bready(axi_bready)
    ,.m_axi_araddr(axi_araddr), .m_axi_arprot(axi_arprot)
    ,.m_axi_arvalid(axi_arvalid), .m_axi_arready(axi_arready)
    ,.m_axi_rdata(axi_rdata), .m_axi_rresp(axi_rresp)
    ,.m_axi_rvalid(axi_rvalid), .m_axi_rready(axi_rready)
    ,.read_stb(read_stb), .write_stb(write_stb), .addr(host_addr), .wdata(host_wdata)
    ,.rdata(host_rdata)
    ,.busy_r(), .busy_w() // bridge never overlaps, so per-channel busy goes unused
    ,.busy(host_busy), .rvalid(host_rvalid), .timeout(host_timeout), .resp(host_resp)
  );

  axil_reg_slave u_regs (
     .m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn)
    ,.awaddr(axi_awaddr), .awprot(axi_awprot), .awvalid(axi_awvalid), .awready(axi_awready)
    ,.wdata(axi_wdata), .wstrb(axi_wstrb), .wvalid(axi_wvalid), .wready(axi_wready)
    ,.bresp(axi_bresp), .bvalid(axi_bvalid), .bready(axi_bready)
    ,.araddr(axi_araddr), .arprot(axi_arprot), .arvalid(axi_arvalid), .arready(axi_arready)
    ,.rdata(axi_rdata), .rresp(axi_rresp), .rvalid(axi_rvalid), .rready(axi_rready)
  );

endmodule

// ==== tests/clk_gen.sv ====
// free-running clock, 40 units per period, and a power-on reset
module clk_gen (
   output logic m_axi_aclk
  ,output logic m_axi_aresetn
);

  initial begin
    m_axi_aclk = 1'b0;
    forever #20 m_axi_aclk = ~m_axi_aclk;
  end

  initial begin
    m_axi_aresetn = 1'b1;
    #1 m_axi_aresetn = 1'b0; // clean falling edge once every flop waits on it
    repeat (8) @(posedge m_axi_aclk);
    #5 m_axi_aresetn = 1'b1; // released off the edge, like the bus inputs
  end

endmodule

// ==== tests/wbaxi_chk.sv ====
// wishbone and axi4-lite protocol checks, bound into wbaxi_top
module wbaxi_chk (
   input logic m_axi_aclk
  ,input logic m_axi_aresetn
  ,input logic cyc
  ,input logic stb
  ,input logic ack
  ,input logic err
  ,input logic awvalid
  ,input logic awready
  ,input logic wvalid
  ,input logic wready
  ,input logic bvalid
  ,input logic bready
  ,input logic arvalid
  ,input logic arready
  ,input logic rvalid
  ,input logic rready
  ,input logic host_rvalid
  ,input logic host_timeout // host abandons, valids may drop
);

  int fail_count = 0; // summed into the verdict at the end of the run

  ack_err_excl: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    !(ack && err))
    else begin
      $error("ack and err high in the same cycle");
      fail_count++;
    end

  // a response needs a live cycle
  resp_in_cycle: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    (ack || err) |-> (cyc && stb))
    else begin
      $error("ack or err outside a wishbone cycle");
      fail_count++;
    end

  aw_hold: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    awvalid && !awready |=> awvalid || host_timeout)
    else begin
      $error("awvalid dropped before awready");
      fail_count++;
    end

  w_hold: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    wvalid && !wready |=> wvalid || host_timeout)
    else begin
      $error("wvalid dropped before wready");
      fail_count++;
    end

  ar_hold: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    arvalid && !arready |=> arvalid || host_timeout)
    else begin
      $error("arvalid dropped before arready");
      fail_count++;
    end

  reset_quiet: assert property (@(posedge m_axi_aclk)
    !m_axi_aresetn |-> !(ack || err || awvalid || wvalid || arvalid || bvalid || rvalid
                         || bready || rready || host_rvalid || host_timeout))
    else begin
      $error("control output high while in reset");
      fail_count++;
    end

endmodule

bind wbaxi_top wbaxi_chk u_chk (
   .m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn)
  ,.cyc(cyc), .stb(stb), .ack(ack), .err(err)
  ,.awvalid(axi_awvalid), .awready(axi_awready)
  ,.wvalid(axi_wvalid), .wready(axi_wready)
  ,.bvalid(axi_bvalid), .bready(axi_bready)
  ,.arvalid(axi_arvalid), .arready(axi_arready)
  ,.rvalid(axi_rvalid), .rready(axi_rready)
  ,.host_rvalid(host_rvalid), .host_timeout(host_timeout)
);

// ==== tests/wbaxi_tb.sv ====
`include "wbaxi_defines.svh"

module wbaxi_tb;

  localparam int reg_count  = `WBAXI_REG_COUNT;
  localparam int ack_limit  = `WBAXI_RESP_TIMEOUT + 20; // cycles one access may take
  localparam int txn_count  = 2 * (reg_count - 1) + 6;  // accesses over all tests
  localparam int clk_period = 40;

  logic                         m_axi_aclk;
  logic                         m_axi_aresetn;
  logic                         cyc;
  logic                         stb;
  logic                         we;
  logic [`WBAXI_ADDR_WIDTH-1:0] adr;
  logic [`WBAXI_DATA_WIDTH-1:0] dat_w;
  logic [`WBAXI_DATA_WIDTH-1:0] dat_r;
  logic                         ack;
  logic                         err;

  logic [`WBAXI_DATA_WIDTH-1:0] shadow [0:reg_count-1]; // expected bank contents
  logic [`WBAXI_DATA_WIDTH-1:0] last_data;              // bus result of the last access
  logic                         last_ack;
  logic                         last_err;
  int errors;
  int tests_run;
  int tests_failed;
  int test_base; // errors seen before the current test
  int pick;

  clk_gen u_clk_gen (.m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn));

  wbaxi_top u_wbaxi_top (
     .m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn)
    ,.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w)
    ,.dat_r(dat_r), .ack(ack), .err(err)
  );

  // one classic cycle, cyc held through the edge where ack or err is seen
  task automatic wb_access(input logic write, input logic [`WBAXI_ADDR_WIDTH-1:0] a,
                           input logic [`WBAXI_DATA_WIDTH-1:0] d);
    int waited;
    waited = 0;
    @(posedge m_axi_aclk);
    #5;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = a;
    dat_w = d;
    do begin
      @(posedge m_axi_aclk);
      #5;
      waited++;
    end while (!ack && !err && waited < ack_limit);
    last_ack  = ack;
    last_err  = err;
    last_data = dat_r;
    if (!ack && !err) begin
      $display("no ack or err within %0d cycles for %s at %h", ack_limit,
               write ? "write" : "read", a);
      errors++;
    end
    @(posedge m_axi_aclk); // response taken on this edge
    #5;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  function automatic string resp_name(input logic a, input logic e);
    if (a && e) return "ack+err";
    if (a) return "ack";
    if (e) return "err";
    return "none";
  endfunction

  task automatic check_resp(input string name, input logic exp_err);
    assert (last_ack == !exp_err && last_err == exp_err) else begin
      $display("Error: %s expected %s actual %s", name, exp_err ? "err" : "ack",
               resp_name(last_ack, last_err));
      errors++;
    end
  endtask

  task automatic check_data(input string name, input logic [`WBAXI_DATA_WIDTH-1:0] exp);
    assert (last_data === exp) else begin
      $display("Error: %s expected %h actual %h", name, exp, last_data);
      errors++;
    end
  endtask

  task automatic start_test();
    test_base = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_base) begin
      tests_failed++;
      $display("test %-14s failed", name);
    end else begin
      $display("test %-14s ok", name);
    end
  endtask

  function automatic logic [`WBAXI_ADDR_WIDTH-1:0] reg_addr(input int idx);
    return `WBAXI_ADDR_WIDTH'(idx * 4); // word aligned byte address
  endfunction

  initial begin
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    dat_w        = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'h432));
    wait (m_axi_aresetn === 1'b0); // reset asserted
    wait (m_axi_aresetn === 1'b1); // and released

    start_test(); // idle bus stays quiet
    repeat (4) begin
      @(posedge m_axi_aclk);
      #5;
      assert (!ack && !err) else begin
        $display("ack or err raised with no cycle on the bus");
        errors++;
      end
    end
    finish_test("reset_idle");

    start_test();
    for (int i = 1; i < reg_count; i++) begin
      shadow[i] = $urandom();
      wb_access(1'b1, reg_addr(i), shadow[i]);
      check_resp($sformatf("write reg %0d", i), 1'b0);
    end
    for (int i = 1; i < reg_count; i++) begin
      wb_access(1'b0, reg_addr(i), '0);
      check_resp($sformatf("read reg %0d", i), 1'b0);
      check_data($sformatf("read reg %0d", i), shadow[i]);
    end
    finish_test("reg_write_read");

    start_test();
    wb_access(1'b0, reg_addr(0), '0);
    check_resp("read id", 1'b0);
    check_data("read id", `WBAXI_ID);
    finish_test("id_read");

    start_test(); // id word refuses writes and keeps its value
    wb_access(1'b1, reg_addr(0), $urandom());
    check_resp("write id", 1'b1);
    wb_access(1'b0, reg_addr(0), '0);
    check_resp("reread id", 1'b0);
    check_data("reread id", `WBAXI_ID);
    finish_test("id_write");

    start_test(); // upper half hangs, host must time out and recover
    wb_access(1'b0, 16'h8000, '0);
    check_resp("unmapped read", 1'b1);
    wb_access(1'b1, 16'hc004, $urandom());
    check_resp("unmapped write", 1'b1);
    pick = $urandom_range(reg_count - 1, 1);
    wb_access(1'b0, reg_addr(pick), '0);
    check_resp("read after timeout", 1'b0);
    check_data("read after timeout", shadow[pick]);
    finish_test("unmapped");

    $display("tests %0d  passed %0d  failed %0d  assertion failures %0d", tests_run,
             tests_run - tests_failed, tests_failed, u_wbaxi_top.u_chk.fail_count);
    if (errors == 0 && u_wbaxi_top.u_chk.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // worst case every access runs to its limit, plus reset and the idle check
  initial begin
    #((txn_count * ack_limit + 16) * clk_period);
    $display("watchdog expired, the run did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== wbaxi.f ====
+incdir+hw
hw/wbaxi_pkg.sv
hw/axi_host_pipelined.sv
hw/wb_host_bridge.sv
hw/axil_reg_slave.sv
hw/wbaxi_top.sv
tests/clk_gen.sv
tests/wbaxi_chk.sv
tests/wbaxi_tb.sv

// ==== Bender.yml ====
package:
  name: wbaxi

sources:
  - include_dirs:
      - hw
    files:
      - hw/wbaxi_pkg.sv
      - hw/axi_host_pipelined.sv
      - hw/wb_host_bridge.sv
      - hw/axil_reg_slave.sv
      - hw/wbaxi_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/clk_gen.sv
      - tests/wbaxi_chk.sv
      - tests/wbaxi_tb.sv
